// ==== bench/core_prof_checker.sv ====
// profiler assertion checker
`include "core_prof_params.svh"

module core_prof_checker
  import core_prof_pkg::*;
  #(
    parameter int ctr_width_p = `PROF_CTR_WIDTH
  )
  (
    input logic                                        clk_i,
    input logic                                        reset_i,
    input logic                                        clear_stats_i,
    input logic                                        print_stat_v_i,
    input tag_t                                        print_stat_tag_i,
    input logic                                        stat_v_i,
    input tag_t                                        stat_tag_i,
    input logic [`PROF_NUM_EVENTS-1:0][ctr_width_p-1:0] counts_i
  );

  int unsigned pulse_fails = 0;
  int unsigned width_fails = 0;
  int unsigned reset_fails = 0;
  int unsigned tag_fails   = 0;
  int unsigned sat_fails   = 0;
  int unsigned fail_count;

  logic [ctr_width_p-1:0] cycle_count;

  assign cycle_count = counts_i[ev_cycle];
  assign fail_count  = pulse_fails + width_fails + reset_fails + tag_fails + sat_fails;

  a_valid_after_print: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !$past(reset_i) |-> (stat_v_i == $past(print_stat_v_i))
  ) else begin
    $error("stat_v_o does not follow print by one cycle");
    pulse_fails++;
  end

  a_valid_one_cycle: assert property (
    @(posedge clk_i) disable iff (reset_i)
    stat_v_i |=> !stat_v_i
  ) else begin
    $error("stat_v_o held longer than one cycle");
    width_fails++;
  end

  // second reset cycle onward, value already forced low
  a_valid_low_in_reset: assert property (
    @(posedge clk_i) (reset_i && $past(reset_i)) |-> !stat_v_i
  ) else begin
    $error("stat_v_o high during reset");
    reset_fails++;
  end

  a_tag_matches_print: assert property (
    @(posedge clk_i) disable iff (reset_i)
    stat_v_i |-> (stat_tag_i == $past(print_stat_tag_i))
  ) else begin
    $error("stat_tag_o differs from the print tag");
    tag_fails++;
  end

  a_cycle_count_saturates: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (&cycle_count && !clear_stats_i) |=> &cycle_count
  ) else begin
    $error("cycle counter left its saturation value");
    sat_fails++;
  end

endmodule

// ==== bench/core_prof_tb.sv ====
// profiler testbench
`include "core_prof_params.svh"

module core_prof_tb
  import core_prof_pkg::*;
  ();

  localparam int ctr_width  = 8;
  localparam int sat_max    = (1 << ctr_width) - 1;
  localparam int num_ev     = `PROF_NUM_EVENTS;
  localparam int unk_idx    = num_ev; // extra tally slot, unknown opcodes
  localparam int wait_limit = 20;

  // instruction classes for stimulus
  localparam int cls_load    = 0;
  localparam int cls_store   = 1;
  localparam int cls_branch  = 2;
  localparam int cls_jal     = 3;
  localparam int cls_jalr    = 4;
  localparam int cls_alu_imm = 5;
  localparam int cls_lui     = 6;
  localparam int cls_auipc   = 7;
  localparam int cls_alu_reg = 8;
  localparam int cls_muldiv  = 9;
  localparam int cls_fence   = 10;
  localparam int cls_unknown = 11;
  localparam int cls_bubble  = 12;

  logic        clk = 1'b0;
  logic        reset;
  logic        exe_valid, exe_stall;
  instr_t      exe_instr;
  logic        branch_miss, jalr_miss;
  logic [4:0]  stalls; // depend, fp, ifetch, md, remote
  logic        clear_stats, print_v;
  tag_t        print_tag;
  prof_event_e stat_sel;
  logic        stat_v;
  tag_t        stat_tag;
  logic [ctr_width-1:0] stat_count;

  // next-cycle stimulus
  logic        n_valid, n_stall, n_bmiss, n_jmiss, n_clear, n_print;
  instr_t      n_instr;
  logic [4:0]  n_stalls;
  tag_t        n_tag;
  prof_event_e n_sel;
  int          n_class;

  int t [0:num_ev];
  int t1 [0:num_ev];
  int exp_snap [0:num_ev];
  int got [0:num_ev];
  tag_t exp_tag;
  int step_count, clear_step, print_step;
  int errors;
  int unsigned chk_fails;
  logic [31:0] lfsr;

  always #2 clk = ~clk;

  core_prof_top #(.ctr_width_p(ctr_width)) u_dut (
    .clk_i(clk), .reset_i(reset),
    .exe_valid_i(exe_valid), .stall_i(exe_stall), .exe_instr_i(exe_instr),
    .branch_mispredict_i(branch_miss), .jalr_mispredict_i(jalr_miss),
    .stall_depend_i(stalls[0]), .stall_fp_i(stalls[1]), .stall_ifetch_wait_i(stalls[2]),
    .stall_md_i(stalls[3]), .stall_remote_req_i(stalls[4]),
    .clear_stats_i(clear_stats), .print_stat_v_i(print_v), .print_stat_tag_i(print_tag),
    .stat_sel_i(stat_sel), .stat_v_o(stat_v), .stat_tag_o(stat_tag),
    .stat_count_o(stat_count)
  );

  bind core_prof_top core_prof_checker #(.ctr_width_p(ctr_width_p)) u_checker (
    .clk_i(clk_i), .reset_i(reset_i), .clear_stats_i(clear_stats_i),
    .print_stat_v_i(print_stat_v_i), .print_stat_tag_i(print_stat_tag_i),
    .stat_v_i(stat_v_o), .stat_tag_i(stat_tag_o), .counts_i(counts)
  );

  // 32-bit fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic instr_t make_instr(input int cls, input logic [24:0] upper);
    instr_t w;
    w = {upper, 7'b0};
    case (cls)
      cls_load:    w[6:0] = `RV32_OP_LOAD;
      cls_store:   w[6:0] = `RV32_OP_STORE;
      cls_branch:  w[6:0] = `RV32_OP_BRANCH;
      cls_jal:     w[6:0] = `RV32_OP_JAL;
      cls_jalr:    w[6:0] = `RV32_OP_JALR;
      cls_alu_imm: w[6:0] = `RV32_OP_IMM;
      cls_lui:     w[6:0] = `RV32_OP_LUI;
      cls_auipc:   w[6:0] = `RV32_OP_AUIPC;
      cls_alu_reg: begin
        w[6:0]   = `RV32_OP_REG;
        w[31:25] = {1'b0, upper[23], 5'b0}; // add or sub
      end
      cls_muldiv: begin
        w[6:0]   = `RV32_OP_REG;
        w[31:25] = `RV32_FUNCT7_MULDIV;
      end
      cls_fence:   w[6:0] = `RV32_OP_FENCE;
      cls_unknown: w[6:0] = 7'b1110011; // system ops are not classified
      default:     w = '0;
    endcase
    return w;
  endfunction

  function automatic int class_event(input int cls);
    case (cls)
      cls_load:    return int'(ev_load);
      cls_store:   return int'(ev_store);
      cls_branch:  return int'(ev_branch);
      cls_jal:     return int'(ev_jal);
      cls_jalr:    return int'(ev_jalr);
      cls_muldiv:  return int'(ev_muldiv);
      cls_fence:   return int'(ev_fence);
      cls_unknown: return unk_idx;
      default:     return int'(ev_alu);
    endcase
  endfunction

  task automatic bump(input int idx);
    if (t[idx] < sat_max) t[idx]++;
  endtask

  task automatic report_mismatch(input string sig, input int expv, input int gotv);
    errors++;
    $display("FAILED at time %0t: %s expected %0d got %0d", $time, sig, expv, gotv);
  endtask

  task automatic set_idle();
    n_valid  = 1'b0;
    n_stall  = 1'b0;
    n_instr  = '0;
    n_class  = cls_bubble;
    n_bmiss  = 1'b0;
    n_jmiss  = 1'b0;
    n_stalls = '0;
  endtask

  task automatic set_instr(input int cls);
    set_idle();
    n_valid = 1'b1;
    n_class = cls;
    n_instr = make_instr(cls, 25'h0a5a5a);
  endtask

  task automatic set_random();
    logic [31:0] r;
    int c;
    draw(2, r);
    n_valid = (r[1:0] != 2'd0);
    n_stall = (r[1:0] == 2'd1);
    draw(4, r);
    c = int'(r[3:0]);
    if (c > cls_bubble) c = c - 11; // extra weight on branch, jal, jalr
    n_class = c;
    draw(25, r);
    n_instr = make_instr(c, r[24:0]);
    draw(2, r);
    n_bmiss = r[0];
    n_jmiss = r[1];
    draw(5, r);
    n_stalls = r[4:0];
  endtask

  // one clock of stimulus plus the expected tallies it implies
  task automatic step();
    logic retire;
    @(posedge clk);
    exe_valid   <= n_valid;
    exe_stall   <= n_stall;
    exe_instr   <= n_instr;
    branch_miss <= n_bmiss;
    jalr_miss   <= n_jmiss;
    stalls      <= n_stalls;
    clear_stats <= n_clear;
    print_v     <= n_print;
    print_tag   <= n_tag;
    stat_sel    <= n_sel;
    if (n_print) begin
      exp_snap   = t1; // counts lag the inputs by two edges
      exp_tag    = n_tag;
      print_step = step_count;
    end
    if (n_clear) begin
      for (int i = 0; i <= num_ev; i++) begin
        t[i]  = 0;
        t1[i] = 0;
      end
      clear_step = step_count;
    end else begin
      t1 = t;
    end
    bump(int'(ev_cycle));
    retire = n_valid && !n_stall && (n_class != cls_bubble);
    if (retire) begin
      bump(int'(ev_instr));
      bump(class_event(n_class));
      if (n_class == cls_branch && n_bmiss) bump(int'(ev_branch_miss));
      if (n_class == cls_jalr && n_jmiss) bump(int'(ev_jalr_miss));
    end
    if (n_stalls[0] && !n_stalls[1]) bump(int'(ev_stall_depend));
    if (n_stalls[1]) bump(int'(ev_stall_fp));
    if (n_stalls[2]) bump(int'(ev_stall_ifetch));
    if (n_stalls[3]) bump(int'(ev_stall_md));
    if (n_stalls[4]) bump(int'(ev_stall_remote_req));
    step_count++;
    n_clear = 1'b0;
    n_print = 1'b0;
  endtask

  task automatic random_steps(input int n, input logic with_clear);
    for (int i = 0; i < n; i++) begin
      set_random();
      n_clear = with_clear && (i == 0);
      step();
    end
  endtask

  task automatic sweep_counts(input logic flow);
    prof_event_e ev;
    for (int e = 0; e < num_ev; e++) begin
      ev    = prof_event_e'(e);
      n_sel = ev;
      if (flow) set_random();
      else set_idle();
      step();
      @(negedge clk);
      got[e] = int'(stat_count);
      assert (got[e] == exp_snap[e])
        else report_mismatch($sformatf("stat_count_o[%s]", ev.name()), exp_snap[e], got[e]);
    end
  endtask

  task automatic print_and_check(input tag_t tag, input logic flow);
    int tries;
    logic seen;
    repeat (3) begin
      set_idle();
      step();
    end
    n_print = 1'b1;
    n_tag   = tag;
    step();
    tries = 0;
    seen  = 1'b0;
    while (!seen && tries < wait_limit) begin
      step();
      @(negedge clk);
      seen = stat_v;
      tries++;
    end
    if (!seen) begin
      errors++;
      $display("timeout: no stat_v_o pulse after print with tag %0d", tag);
    end else begin
      assert (stat_tag == exp_tag)
        else report_mismatch("stat_tag_o", int'(exp_tag), int'(stat_tag));
    end
    sweep_counts(flow);
  endtask

  task automatic check_instr_sum();
    int sum;
    sum = got[ev_load] + got[ev_store] + got[ev_branch] + got[ev_jal] + got[ev_jalr]
        + got[ev_alu] + got[ev_muldiv] + got[ev_fence] + exp_snap[unk_idx];
    assert (got[ev_instr] == sum) else report_mismatch("instr vs class sum", sum, got[ev_instr]);
  endtask

  initial begin
    reset = 1'b1;
    exe_valid = 1'b0;
    exe_stall = 1'b0;
    exe_instr = '0;
    branch_miss = 1'b0;
    jalr_miss = 1'b0;
    stalls = '0;
    clear_stats = 1'b0;
    print_v = 1'b0;
    print_tag = '0;
    stat_sel = ev_cycle;
    lfsr = 32'd65983;
    errors = 0;
    step_count = 0;
    clear_step = 0;
    print_step = 0;
    exp_tag = '0;
    for (int i = 0; i <= num_ev; i++) begin
      t[i] = 0;
      t1[i] = 0;
      exp_snap[i] = 0;
      got[i] = 0;
    end
    set_idle();
    n_clear = 1'b0;
    n_print = 1'b0;
    n_tag = '0;
    n_sel = ev_cycle;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    random_steps(60, 1'b1); // all classes, stalls and invalid cycles
    print_and_check(8'h01, 1'b0);
    check_instr_sum();

    random_steps(40, 1'b1);
    set_instr(cls_branch);
    n_stall = 1'b1;
    n_bmiss = 1'b1; // stalled branch, no miss
    step();
    set_instr(cls_load);
    n_bmiss = 1'b1;
    n_jmiss = 1'b1;
    step();
    set_instr(cls_jalr);
    n_valid = 1'b0;
    n_jmiss = 1'b1;
    step();
    set_instr(cls_branch);
    n_bmiss = 1'b1;
    step();
    set_instr(cls_jalr);
    n_jmiss = 1'b1;
    step();
    print_and_check(8'h02, 1'b0);

    random_steps(40, 1'b1);
    set_idle();
    n_stalls = 5'b00011; // fp blames over depend
    step();
    print_and_check(8'h03, 1'b0);

    random_steps(10, 1'b0);
    set_instr(cls_store); // lost to the clear below
    step();
    set_instr(cls_jal);
    n_clear = 1'b1;
    step();
    print_and_check(8'h04, 1'b0);
    assert (got[ev_cycle] == print_step - clear_step - 1)
      else report_mismatch("stat_count_o[ev_cycle]", print_step - clear_step - 1, got[ev_cycle]);
    assert (got[ev_store] == 0) else report_mismatch("stat_count_o[ev_store]", 0, got[ev_store]);
    assert (got[ev_jal] == 1) else report_mismatch("stat_count_o[ev_jal]", 1, got[ev_jal]);

    random_steps(300, 1'b1);
    print_and_check(8'h05, 1'b0);
    assert (got[ev_cycle] == sat_max)
      else report_mismatch("stat_count_o[ev_cycle]", sat_max, got[ev_cycle]);

    random_steps(20, 1'b1);
    print_and_check(8'ha5, 1'b1);
    sweep_counts(1'b1); // frozen while new events arrive

    repeat (3) @(posedge clk);
    chk_fails = u_dut.u_checker.fail_count;
    $display("check errors: %0d, assertion failures: %0d", errors, chk_fails);
    if (errors == 0 && chk_fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+source
source/core_prof_pkg.sv
source/core_prof_event_classify.sv
source/core_prof_sat_counter.sv
source/core_prof_snapshot.sv
source/core_prof_top.sv
bench/core_prof_checker.sv
bench/core_prof_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the profiler testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --assert -j 0 -f project.f --top-module core_prof_tb -o core_prof_sim \
  && ./obj_dir/core_prof_sim +verilator+error+limit+1000 > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
if grep -q "Finished with errors" sim.log; then
  exit 1
fi
exit 0

// ==== source/core_prof_event_classify.sv ====
// execute stage event classifier
`include "core_prof_params.svh"

module core_prof_event_classify
  import core_prof_pkg::*;
  (
    input  logic       clk_i,
    input  logic       reset_i,

    input  logic       exe_valid_i,
    input  logic       stall_i,
    input  instr_t     exe_instr_i,

    input  logic       branch_mispredict_i,
    input  logic       jalr_mispredict_i,

    input  logic       stall_depend_i,
    input  logic       stall_fp_i,
    input  logic       stall_ifetch_wait_i,
    input  logic       stall_md_i,
    input  logic       stall_remote_req_i,

    output event_vec_t event_o
  );

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic       retire;

  logic       is_branch;
  logic       is_jalr;

  event_vec_t event_n;
  event_vec_t event_r;

  assign opcode = exe_instr_i[6:0];
  assign funct7 = exe_instr_i[31:25];

  // a zero word is a bubble
  assign retire = exe_valid_i & ~stall_i & (exe_instr_i != '0);

  assign is_branch = (opcode == `RV32_OP_BRANCH);
  assign is_jalr   = (opcode == `RV32_OP_JALR);

  always_comb begin
    event_n = '0;

    // instruction classes, exactly one per retire
    if (retire) begin
      event_n[ev_instr] = 1'b1;
      case (opcode)
        `RV32_OP_LOAD:   event_n[ev_load]   = 1'b1;
        `RV32_OP_STORE:  event_n[ev_store]  = 1'b1;
        `RV32_OP_BRANCH: event_n[ev_branch] = 1'b1;
        `RV32_OP_JAL:    event_n[ev_jal]    = 1'b1;
        `RV32_OP_JALR:   event_n[ev_jalr]   = 1'b1;
        `RV32_OP_IMM,
        `RV32_OP_LUI,
        `RV32_OP_AUIPC:  event_n[ev_alu]    = 1'b1;
        `RV32_OP_REG: begin
          if (funct7 == `RV32_FUNCT7_MULDIV) begin
            event_n[ev_muldiv] = 1'b1;
          end else begin
            event_n[ev_alu] = 1'b1;
          end
        end
        `RV32_OP_FENCE:  event_n[ev_fence]  = 1'b1;
        default: ; // unknown opcode, instr only
      endcase
    end

    // mispredicts only on a retiring instr of the matching kind
    event_n[ev_branch_miss] = retire & is_branch & branch_mispredict_i;
    event_n[ev_jalr_miss]   = retire & is_jalr & jalr_mispredict_i;

    // fp stall takes the blame when both are up
    event_n[ev_stall_depend]     = stall_depend_i & ~stall_fp_i;
    event_n[ev_stall_fp]         = stall_fp_i;
    event_n[ev_stall_ifetch]     = stall_ifetch_wait_i;
    event_n[ev_stall_md]         = stall_md_i;
    event_n[ev_stall_remote_req] = stall_remote_req_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      event_r <= '0;
    end else begin
      event_r           <= event_n;
      event_r[ev_cycle] <= 1'b1; // every cycle out of reset
    end
  end

  assign event_o = event_r;

endmodule

// ==== source/core_prof_params.svh ====
// core profiler parameters
`ifndef CORE_PROF_PARAMS_SVH
`define CORE_PROF_PARAMS_SVH

// counter and event sizing
`define PROF_CTR_WIDTH   32
`define PROF_NUM_EVENTS  17
`define PROF_TAG_WIDTH   8

// rv32 major opcodes, bits [6:0] of the instruction word
`define RV32_OP_LOAD     7'b0000011
`define RV32_OP_STORE    7'b0100011
`define RV32_OP_BRANCH   7'b1100011
`define RV32_OP_JAL      7'b1101111
`define RV32_OP_JALR     7'b1100111
`define RV32_OP_REG      7'b0110011
`define RV32_OP_IMM      7'b0010011
`define RV32_OP_LUI      7'b0110111
`define RV32_OP_AUIPC    7'b0010111
`define RV32_OP_FENCE    7'b0001111

`define RV32_FUNCT7_MULDIV 7'b0000001 // m extension on OP

`endif

// ==== source/core_prof_pkg.sv ====
// core profiler types
`include "core_prof_params.svh"

package core_prof_pkg;

  // event index, also the counter number
  typedef enum logic [4:0] {
    ev_cycle            = 5'd0,
    ev_instr            = 5'd1,
    ev_load             = 5'd2,
    ev_store            = 5'd3,
    ev_branch           = 5'd4,
    ev_branch_miss      = 5'd5,
    ev_jal              = 5'd6,
    ev_jalr             = 5'd7,
    ev_jalr_miss        = 5'd8,
    ev_alu              = 5'd9,
    ev_muldiv           = 5'd10,
    ev_fence            = 5'd11,
    ev_stall_depend     = 5'd12,
    ev_stall_fp         = 5'd13,
    ev_stall_ifetch     = 5'd14,
    ev_stall_md         = 5'd15,
    ev_stall_remote_req = 5'd16
  } prof_event_e;

  // one bit per event
  typedef logic [`PROF_NUM_EVENTS-1:0] event_vec_t;

  // raw instruction in execute
  typedef logic [31:0] instr_t;

  // print tag, carried through with the snapshot
  typedef logic [`PROF_TAG_WIDTH-1:0] tag_t;

endpackage

// ==== source/core_prof_sat_counter.sv ====
// saturating event counter
`include "core_prof_params.svh"

module core_prof_sat_counter
  #(
    parameter int ctr_width_p = `PROF_CTR_WIDTH
  )
  (
    input  logic                   clk_i,
    input  logic                   reset_i,

    input  logic                   clear_i,
    input  logic                   inc_i,

    output logic [ctr_width_p-1:0] count_o
  );

  logic [ctr_width_p-1:0] count_r;
  logic                   at_max;

  assign at_max = &count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (clear_i) begin
      count_r <= '0; // clear wins over a pending increment
    end else if (inc_i && !at_max) begin
      count_r <= count_r + 1'b1;
    end
  end

  assign count_o = count_r;

endmodule

// ==== source/core_prof_snapshot.sv ====
// counter snapshot and readout
`include "core_prof_params.svh"

module core_prof_snapshot
  import core_prof_pkg::*;
  #(
    parameter int ctr_width_p = `PROF_CTR_WIDTH
  )
  (
    input  logic                                        clk_i,
    input  logic                                        reset_i,

    input  logic [`PROF_NUM_EVENTS-1:0][ctr_width_p-1:0] counts_i,

    input  logic                                        print_v_i,
    input  tag_t                                        print_tag_i,

    input  prof_event_e                                 sel_i,

    output logic                                        stat_v_o,
    output tag_t                                        stat_tag_o,
    output logic [ctr_width_p-1:0]                      stat_count_o
  );

  logic [`PROF_NUM_EVENTS-1:0][ctr_width_p-1:0] snap_r;
  tag_t                                         tag_r;
  logic                                         stat_v_r;
  logic                                         sel_in_range;

  // frozen copy, taken from the values held before the print edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      snap_r <= '0;
      tag_r  <= '0;
    end else if (print_v_i) begin
      snap_r <= counts_i;
      tag_r  <= print_tag_i;
    end
  end

  // one cycle valid pulse after each print
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stat_v_r <= 1'b0;
    end else begin
      stat_v_r <= print_v_i;
    end
  end

  // 5-bit select can name more slots than there are counters
  assign sel_in_range = (int'(sel_i) < `PROF_NUM_EVENTS);

  assign stat_count_o = sel_in_range ? snap_r[sel_i] : '0;
  assign stat_tag_o   = tag_r;
  assign stat_v_o     = stat_v_r;

endmodule

// ==== source/core_prof_top.sv ====
// core event profiler
`include "core_prof_params.svh"

module core_prof_top
  import core_prof_pkg::*;
  #(
    parameter int ctr_width_p = `PROF_CTR_WIDTH
  )
  (
    input  logic                   clk_i,
    input  logic                   reset_i,

    // execute stage
    input  logic                   exe_valid_i,
    input  logic                   stall_i,
    input  instr_t                 exe_instr_i,

    input  logic                   branch_mispredict_i,
    input  logic                   jalr_mispredict_i,

    // stall cause levels
    input  logic                   stall_depend_i,
    input  logic                   stall_fp_i,
    input  logic                   stall_ifetch_wait_i,
    input  logic                   stall_md_i,
    input  logic                   stall_remote_req_i,

    // control strobes
    input  logic                   clear_stats_i,
    input  logic                   print_stat_v_i,
    input  tag_t                   print_stat_tag_i,

    // readout
    input  prof_event_e            stat_sel_i,
    output logic                   stat_v_o,
    output tag_t                   stat_tag_o,
    output logic [ctr_width_p-1:0] stat_count_o
  );

  event_vec_t                                   event_r;
  logic [`PROF_NUM_EVENTS-1:0][ctr_width_p-1:0] counts;

  core_prof_event_classify u_classify (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .exe_valid_i         (exe_valid_i),
    .stall_i             (stall_i),
    .exe_instr_i         (exe_instr_i),
    .branch_mispredict_i (branch_mispredict_i),
    .jalr_mispredict_i   (jalr_mispredict_i),
    .stall_depend_i      (stall_depend_i),
    .stall_fp_i          (stall_fp_i),
    .stall_ifetch_wait_i (stall_ifetch_wait_i),
    .stall_md_i          (stall_md_i),
    .stall_remote_req_i  (stall_remote_req_i),
    .event_o             (event_r)
  );

  // one counter per event bit
  for (genvar i = 0; i < `PROF_NUM_EVENTS; i++) begin : g_ctr
    core_prof_sat_counter #(
      .ctr_width_p (ctr_width_p)
    ) u_ctr (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .clear_i (clear_stats_i),
      .inc_i   (event_r[i]),
      .count_o (counts[i])
    );
  end

  core_prof_snapshot #(
    .ctr_width_p (ctr_width_p)
  ) u_snapshot (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .counts_i     (counts),
    .print_v_i    (print_stat_v_i),
    .print_tag_i  (print_stat_tag_i),
    .sel_i        (stat_sel_i),
    .stat_v_o     (stat_v_o),
    .stat_tag_o   (stat_tag_o),
    .stat_count_o (stat_count_o)
  );

endmodule
